// ==== hw/rv_exe_pkg.sv ====
//********************
// shared types for the rv32i execute path
// widths are fixed to RV32, no compressed or M extension
//********************
package rv_exe_pkg;

	localparam int XLEN   = 32;
	localparam int REG_AW = 5;

	// COPY2 forwards the second operand, used by lui
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_COPY2
	} alu_op_e;

	typedef enum logic [1:0] {
		SRC1_ZERO,
		SRC1_REG1,
		SRC1_PC
	} src1_sel_e;

	typedef enum logic [1:0] {
		SRC2_ZERO,
		SRC2_REG2,
		SRC2_IMM,
		SRC2_FOUR
	} src2_sel_e;

	// JUMP covers both jal and jalr
	typedef enum logic [2:0] {
		BR_NONE,
		BR_BEQ,
		BR_BNE,
		BR_BLT,
		BR_BGE,
		BR_BLTU,
		BR_BGEU,
		BR_JUMP
	} branch_e;

	typedef enum logic [1:0] {
		ST_NONE,
		ST_SB,
		ST_SH,
		ST_SW
	} store_e;

	typedef enum logic [2:0] {
		LD_NONE,
		LD_LB,
		LD_LH,
		LD_LW,
		LD_LBU,
		LD_LHU
	} load_e;

	// decode to execute
	typedef struct packed {
		logic              valid;
		logic [XLEN-1:0]   pc;
		logic [XLEN-1:0]   rs1_data;
		logic [XLEN-1:0]   rs2_data;
		logic [XLEN-1:0]   imm;
		alu_op_e           alu_op;
		src1_sel_e         src1_sel;
		src2_sel_e         src2_sel;
		branch_e           branch;
		store_e            store;
		load_e             load;
		logic              we;
		logic [REG_AW-1:0] rd;
	} exe_ctrl_t;

	// execute to memory stage
	typedef struct packed {
		logic              valid;
		logic [XLEN-1:0]   pc;
		logic [XLEN-1:0]   alu_result;
		logic              mem_we;
		logic [XLEN-1:0]   mem_wdata;
		load_e             load;
		logic              we;
		logic [REG_AW-1:0] rd;
		logic              branch_req;
	} exe_result_t;

endpackage

// ==== hw/rv_alu.sv ====
`timescale 1ns/1ps
//********************
// combinational rv32i alu
// zero and less flags always come from src1 - src2
//********************
module rv_alu (
	input  logic [rv_exe_pkg::XLEN-1:0] src1_i,
	input  logic [rv_exe_pkg::XLEN-1:0] src2_i,
	input  rv_exe_pkg::alu_op_e         op_i,
	output logic [rv_exe_pkg::XLEN-1:0] result_o,
	output logic                        zero_o,
	output logic                        less_o,
	output logic                        less_u_o
);
	import rv_exe_pkg::*;

	localparam int SHAMT_W = $clog2(XLEN);

	logic [XLEN:0]      diff_ext;
	logic [XLEN-1:0]    diff;
	logic [SHAMT_W-1:0] shamt;

	// extra msb holds the borrow
	assign diff_ext = {1'b0, src1_i} - {1'b0, src2_i};
	assign diff     = diff_ext[XLEN-1:0];
	assign shamt    = src2_i[SHAMT_W-1:0];

	assign zero_o   = (diff == '0);
	assign less_u_o = diff_ext[XLEN];
	// when the signs differ the negative operand is the smaller one
	assign less_o   = (src1_i[XLEN-1] != src2_i[XLEN-1]) ? src1_i[XLEN-1] : diff[XLEN-1];

	always_comb begin
		case (op_i)
		ALU_ADD:   result_o = src1_i + src2_i;
		ALU_SUB:   result_o = diff;
		ALU_SLL:   result_o = src1_i << shamt;
		ALU_SLT:   result_o = {{(XLEN-1){1'b0}}, less_o};
		ALU_SLTU:  result_o = {{(XLEN-1){1'b0}}, less_u_o};
		ALU_XOR:   result_o = src1_i ^ src2_i;
		ALU_SRL:   result_o = src1_i >> shamt;
		ALU_SRA:   result_o = $signed(src1_i) >>> shamt;
		ALU_OR:    result_o = src1_i | src2_i;
		ALU_AND:   result_o = src1_i & src2_i;
		ALU_COPY2: result_o = src2_i;
		default:   result_o = '0;
		endcase
	end

endmodule

// ==== hw/rv_decode.sv ====
`timescale 1ns/1ps
//********************
// rv32i decoder, one registered stage
// unknown opcodes pass as valid but never write, store or branch
//********************
module rv_decode (
	input  logic                        clk_i,
	input  logic                        reset_i,
	input  logic                        valid_i,
	input  logic [31:0]                 inst_i,
	input  logic [rv_exe_pkg::XLEN-1:0] pc_i,
	input  logic [rv_exe_pkg::XLEN-1:0] rs1_data_i,
	input  logic [rv_exe_pkg::XLEN-1:0] rs2_data_i,
	output rv_exe_pkg::exe_ctrl_t       ctrl_o
);
	import rv_exe_pkg::*;

	// major opcodes handled here
	typedef enum logic [6:0] {
		OPC_LOAD   = 7'b0000011,
		OPC_OP_IMM = 7'b0010011,
		OPC_AUIPC  = 7'b0010111,
		OPC_STORE  = 7'b0100011,
		OPC_OP     = 7'b0110011,
		OPC_LUI    = 7'b0110111,
		OPC_BRANCH = 7'b1100011,
		OPC_JALR   = 7'b1100111,
		OPC_JAL    = 7'b1101111
	} opcode_e;

	opcode_e         opcode;
	logic [2:0]      funct3;
	logic            funct7_b5;
	logic [XLEN-1:0] imm_itype;
	logic [XLEN-1:0] imm_stype;
	logic [XLEN-1:0] imm_btype;
	logic [XLEN-1:0] imm_utype;
	logic [XLEN-1:0] imm_jtype;
	alu_op_e         arith_op;
	exe_ctrl_t       ctrl_d;

	assign opcode    = opcode_e'(inst_i[6:0]);
	assign funct3    = inst_i[14:12];
	assign funct7_b5 = inst_i[30];

	// sign-extended immediates
	assign imm_itype = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_stype = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
	assign imm_btype = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
		inst_i[11:8], 1'b0};
	assign imm_utype = {inst_i[31:12], 12'b0};
	assign imm_jtype = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
		inst_i[30:21], 1'b0};

	// OP and OP-IMM share funct3, sub only exists on OP
	always_comb begin
		case (funct3)
		3'b000:  arith_op = (opcode == OPC_OP && funct7_b5) ? ALU_SUB : ALU_ADD;
		3'b001:  arith_op = ALU_SLL;
		3'b010:  arith_op = ALU_SLT;
		3'b011:  arith_op = ALU_SLTU;
		3'b100:  arith_op = ALU_XOR;
		3'b101:  arith_op = funct7_b5 ? ALU_SRA : ALU_SRL;
		3'b110:  arith_op = ALU_OR;
		default: arith_op = ALU_AND;
		endcase
	end

	always_comb begin
		ctrl_d          = '0;
		ctrl_d.valid    = valid_i;
		ctrl_d.pc       = pc_i;
		ctrl_d.rs1_data = rs1_data_i;
		ctrl_d.rs2_data = rs2_data_i;
		ctrl_d.rd       = inst_i[11:7];
		ctrl_d.imm      = imm_itype;
		ctrl_d.alu_op   = ALU_ADD;
		ctrl_d.src1_sel = SRC1_REG1;
		ctrl_d.src2_sel = SRC2_IMM;
		ctrl_d.branch   = BR_NONE;
		ctrl_d.store    = ST_NONE;
		ctrl_d.load     = LD_NONE;
		ctrl_d.we       = 1'b0;
		case (opcode)
		OPC_OP: begin
			ctrl_d.alu_op   = arith_op;
			ctrl_d.src2_sel = SRC2_REG2;
			ctrl_d.we       = 1'b1;
		end
		OPC_OP_IMM: begin
			ctrl_d.alu_op = arith_op;
			ctrl_d.we     = 1'b1;
		end
		OPC_LUI: begin
			ctrl_d.imm      = imm_utype;
			ctrl_d.alu_op   = ALU_COPY2;
			ctrl_d.src1_sel = SRC1_ZERO;
			ctrl_d.we       = 1'b1;
		end
		OPC_AUIPC: begin
			ctrl_d.imm      = imm_utype;
			ctrl_d.src1_sel = SRC1_PC;
			ctrl_d.we       = 1'b1;
		end
		OPC_JAL, OPC_JALR: begin
			// link address pc+4, target is resolved elsewhere
			if (opcode == OPC_JAL) begin
				ctrl_d.imm = imm_jtype;
			end
			ctrl_d.src1_sel = SRC1_PC;
			ctrl_d.src2_sel = SRC2_FOUR;
			ctrl_d.branch   = BR_JUMP;
			ctrl_d.we       = 1'b1;
		end
		OPC_BRANCH: begin
			ctrl_d.imm      = imm_btype;
			ctrl_d.alu_op   = ALU_SUB;
			ctrl_d.src2_sel = SRC2_REG2;
			case (funct3)
			3'b000:  ctrl_d.branch = BR_BEQ;
			3'b001:  ctrl_d.branch = BR_BNE;
			3'b100:  ctrl_d.branch = BR_BLT;
			3'b101:  ctrl_d.branch = BR_BGE;
			3'b110:  ctrl_d.branch = BR_BLTU;
			3'b111:  ctrl_d.branch = BR_BGEU;
			default: ctrl_d.branch = BR_NONE;
			endcase
		end
		OPC_LOAD: begin
			case (funct3)
			3'b000:  ctrl_d.load = LD_LB;
			3'b001:  ctrl_d.load = LD_LH;
			3'b010:  ctrl_d.load = LD_LW;
			3'b100:  ctrl_d.load = LD_LBU;
			3'b101:  ctrl_d.load = LD_LHU;
			default: ctrl_d.load = LD_NONE;
			endcase
			ctrl_d.we = (ctrl_d.load != LD_NONE);
		end
		OPC_STORE: begin
			ctrl_d.imm = imm_stype;
			case (funct3)
			3'b000:  ctrl_d.store = ST_SB;
			3'b001:  ctrl_d.store = ST_SH;
			3'b010:  ctrl_d.store = ST_SW;
			default: ctrl_d.store = ST_NONE;
			endcase
		end
		default: begin
			ctrl_d.we = 1'b0;
		end
		endcase
		// a bubble has no side effects downstream
		if (!valid_i) begin
			ctrl_d.we     = 1'b0;
			ctrl_d.branch = BR_NONE;
			ctrl_d.store  = ST_NONE;
			ctrl_d.load   = LD_NONE;
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			ctrl_o.valid  <= 1'b0;
			ctrl_o.we     <= 1'b0;
			ctrl_o.branch <= BR_NONE;
			ctrl_o.store  <= ST_NONE;
			ctrl_o.load   <= LD_NONE;
		end else begin
			ctrl_o <= ctrl_d;
		end
	end

endmodule

// ==== hw/rv_execute.sv ====
`timescale 1ns/1ps
//********************
// execute stage, one registered stage after decode
// no branch target, no forwarding
//********************
module rv_execute #(
	parameter logic [rv_exe_pkg::XLEN-1:0] PC_RESET = 32'h8000_0000
) (
	input  logic                    clk_i,
	input  logic                    reset_i,
	input  rv_exe_pkg::exe_ctrl_t   ctrl_i,
	output rv_exe_pkg::exe_result_t result_o
);
	import rv_exe_pkg::*;

	logic [XLEN-1:0] src1;
	logic [XLEN-1:0] src2;
	logic [XLEN-1:0] alu_result;
	logic            alu_zero;
	logic            alu_less;
	logic            alu_less_u;
	logic            branch_req;
	logic [XLEN-1:0] store_mask;
	exe_result_t     result_d;

	// operand selects
	always_comb begin
		case (ctrl_i.src1_sel)
		SRC1_REG1: src1 = ctrl_i.rs1_data;
		SRC1_PC:   src1 = ctrl_i.pc;
		default:   src1 = '0;
		endcase
	end

	always_comb begin
		case (ctrl_i.src2_sel)
		SRC2_REG2: src2 = ctrl_i.rs2_data;
		SRC2_IMM:  src2 = ctrl_i.imm;
		SRC2_FOUR: src2 = XLEN'(4);
		default:   src2 = '0;
		endcase
	end

	rv_alu u_rv_alu (
		.src1_i   (src1),
		.src2_i   (src2),
		.op_i     (ctrl_i.alu_op),
		.result_o (alu_result),
		.zero_o   (alu_zero),
		.less_o   (alu_less),
		.less_u_o (alu_less_u)
	);

	// flags compare rs1 with rs2 because branches select REG1 and REG2
	always_comb begin
		case (ctrl_i.branch)
		BR_BEQ:  branch_req = alu_zero;
		BR_BNE:  branch_req = ~alu_zero;
		BR_BLT:  branch_req = alu_less;
		BR_BGE:  branch_req = ~alu_less;
		BR_BLTU: branch_req = alu_less_u;
		BR_BGEU: branch_req = ~alu_less_u;
		BR_JUMP: branch_req = 1'b1;
		default: branch_req = 1'b0;
		endcase
	end

	// store data keeps the low bytes only
	always_comb begin
		case (ctrl_i.store)
		ST_SB:   store_mask = {{(XLEN-8){1'b0}}, 8'hff};
		ST_SH:   store_mask = {{(XLEN-16){1'b0}}, 16'hffff};
		ST_SW:   store_mask = '1;
		default: store_mask = '0;
		endcase
	end

	always_comb begin
		result_d.valid      = ctrl_i.valid;
		result_d.pc         = ctrl_i.pc;
		result_d.alu_result = alu_result;
		result_d.mem_we     = (ctrl_i.store != ST_NONE);
		result_d.mem_wdata  = ctrl_i.rs2_data & store_mask;
		result_d.load       = ctrl_i.load;
		result_d.we         = ctrl_i.we;
		result_d.rd         = ctrl_i.rd;
		result_d.branch_req = branch_req;
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			result_o.valid      <= 1'b0;
			result_o.pc         <= PC_RESET;
			result_o.mem_we     <= 1'b0;
			result_o.load       <= LD_NONE;
			result_o.we         <= 1'b0;
			result_o.branch_req <= 1'b0;
		end else begin
			result_o <= result_d;
		end
	end

endmodule

// ==== hw/rv_exe_top.sv ====
`timescale 1ns/1ps
//********************
// decode plus execute, result two cycles after valid_i
// register values come from outside, no back-pressure
//********************
module rv_exe_top #(
	parameter logic [rv_exe_pkg::XLEN-1:0] PC_RESET = 32'h8000_0000
) (
	input  logic                        clk_i,
	input  logic                        reset_i,
	input  logic                        valid_i,
	input  logic [31:0]                 inst_i,
	input  logic [rv_exe_pkg::XLEN-1:0] pc_i,
	input  logic [rv_exe_pkg::XLEN-1:0] rs1_data_i,
	input  logic [rv_exe_pkg::XLEN-1:0] rs2_data_i,
	output rv_exe_pkg::exe_result_t     result_o
);
	import rv_exe_pkg::*;

	// packet between the two stages
	exe_ctrl_t ctrl;

	rv_decode u_rv_decode (
		.clk_i      (clk_i),
		.reset_i    (reset_i),
		.valid_i    (valid_i),
		.inst_i     (inst_i),
		.pc_i       (pc_i),
		.rs1_data_i (rs1_data_i),
		.rs2_data_i (rs2_data_i),
		.ctrl_o     (ctrl)
	);

	rv_execute #(
		.PC_RESET (PC_RESET)
	) u_rv_execute (
		.clk_i    (clk_i),
		.reset_i  (reset_i),
		.ctrl_i   (ctrl),
		.result_o (result_o)
	);

endmodule

// ==== sim/rv_exe_top_chk.sv ====
`timescale 1ns/1ps
//********************
// reference model and assertions, bound into rv_exe_top
// result expected exactly two edges after valid_i
//********************
module rv_exe_top_chk #(
	parameter logic [rv_exe_pkg::XLEN-1:0] PC_RESET = 32'h8000_0000
) (
	input logic                        clk_i,
	input logic                        reset_i,
	input logic                        valid_i,
	input logic [31:0]                 inst_i,
	input logic [rv_exe_pkg::XLEN-1:0] pc_i,
	input logic [rv_exe_pkg::XLEN-1:0] rs1_data_i,
	input logic [rv_exe_pkg::XLEN-1:0] rs2_data_i,
	input rv_exe_pkg::exe_result_t     result_i
);
	import rv_exe_pkg::*;

	int unsigned fail_count = 0;
	exe_result_t expect_d;
	exe_result_t expect_q1;
	exe_result_t expect_q2;

	// expected packet straight from the rv32i encoding
	function automatic exe_result_t model(input logic [31:0] inst, input logic [31:0] pc,
		input logic [31:0] a, input logic [31:0] b);
		logic [31:0]        imm_i;
		logic [31:0]        imm_s;
		logic [31:0]        op_b;
		logic signed [31:0] sra;
		logic [2:0]         f3;
		exe_result_t        r;
		imm_i = {{20{inst[31]}}, inst[31:20]};
		imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
		f3    = inst[14:12];
		op_b  = (inst[6:0] == 7'h33) ? b : imm_i;
		sra   = $signed(a) >>> op_b[4:0];
		r       = '0;
		r.valid = 1'b1;
		r.pc    = pc;
		r.rd    = inst[11:7];
		case (inst[6:0])
		7'h33, 7'h13: begin
			r.we = 1'b1;
			case (f3)
			3'd0:    r.alu_result = (inst[5] && inst[30]) ? a - op_b : a + op_b;
			3'd1:    r.alu_result = a << op_b[4:0];
			3'd2:    r.alu_result = {31'b0, $signed(a) < $signed(op_b)};
			3'd3:    r.alu_result = {31'b0, a < op_b};
			3'd4:    r.alu_result = a ^ op_b;
			3'd5:    r.alu_result = inst[30] ? sra : a >> op_b[4:0];
			3'd6:    r.alu_result = a | op_b;
			default: r.alu_result = a & op_b;
			endcase
		end
		7'h37: begin
			r.we         = 1'b1;
			r.alu_result = {inst[31:12], 12'b0};
		end
		7'h17: begin
			r.we         = 1'b1;
			r.alu_result = pc + {inst[31:12], 12'b0};
		end
		7'h6f, 7'h67: begin
			r.we         = 1'b1;
			r.branch_req = 1'b1;
			r.alu_result = pc + 32'd4;
		end
		7'h63: begin
			r.alu_result = a - b;
			case (f3)
			3'd0:    r.branch_req = (a == b);
			3'd1:    r.branch_req = (a != b);
			3'd4:    r.branch_req = ($signed(a) < $signed(b));
			3'd5:    r.branch_req = ($signed(a) >= $signed(b));
			3'd6:    r.branch_req = (a < b);
			3'd7:    r.branch_req = (a >= b);
			default: r.branch_req = 1'b0;
			endcase
		end
		7'h03: begin
			r.alu_result = a + imm_i;
			case (f3)
			3'd0:    r.load = LD_LB;
			3'd1:    r.load = LD_LH;
			3'd2:    r.load = LD_LW;
			3'd4:    r.load = LD_LBU;
			3'd5:    r.load = LD_LHU;
			default: r.load = LD_NONE;
			endcase
			r.we = (r.load != LD_NONE);
		end
		7'h23: begin
			r.alu_result = a + imm_s;
			r.mem_we     = (f3 <= 3'd2);
			case (f3)
			3'd0:    r.mem_wdata = {24'b0, b[7:0]};
			3'd1:    r.mem_wdata = {16'b0, b[15:0]};
			3'd2:    r.mem_wdata = b;
			default: r.mem_wdata = '0;
			endcase
		end
		default: begin
			r.we = 1'b0;
		end
		endcase
		return r;
	endfunction

	always_comb begin
		if (valid_i) begin
			expect_d = model(inst_i, pc_i, rs1_data_i, rs2_data_i);
		end else begin
			expect_d = '0;
		end
	end

	// two stages, same as decode plus execute
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			expect_q1 <= '0;
			expect_q2 <= '0;
		end else begin
			expect_q1 <= expect_d;
			expect_q2 <= expect_q1;
		end
	end

	a_valid: assert property (@(posedge clk_i) disable iff (reset_i)
		result_i.valid == expect_q2.valid)
		else begin
			fail_count++;
			$error("FAIL %0t: valid does not follow valid_i by two cycles", $time);
		end

	a_idle: assert property (@(posedge clk_i) disable iff (reset_i)
		!result_i.valid |-> !result_i.mem_we && !result_i.branch_req && !result_i.we)
		else begin
			fail_count++;
			$error("FAIL %0t: side effect raised without valid", $time);
		end

	// pc field still holds its reset value on the first edge out of reset
	a_pc_reset: assert property (@(posedge clk_i) disable iff (reset_i)
		$fell(reset_i) |-> result_i.pc == PC_RESET)
		else begin
			fail_count++;
			$error("FAIL %0t: pc after reset %h, expected %h", $time,
				$sampled(result_i.pc), PC_RESET);
		end

	a_ctrl: assert property (@(posedge clk_i) disable iff (reset_i)
		result_i.valid |-> result_i.we == expect_q2.we && result_i.load == expect_q2.load
			&& result_i.mem_we == expect_q2.mem_we && result_i.pc == expect_q2.pc
			&& result_i.branch_req == expect_q2.branch_req)
		else begin
			fail_count++;
			$error("FAIL %0t: control fields, pc %h", $time, $sampled(expect_q2.pc));
		end

	a_rd: assert property (@(posedge clk_i) disable iff (reset_i)
		result_i.valid && expect_q2.we |-> result_i.rd == expect_q2.rd)
		else begin
			fail_count++;
			$error("FAIL %0t: rd, expected %0d", $time, $sampled(expect_q2.rd));
		end

	// branches are included, their alu result is rs1 - rs2
	a_result: assert property (@(posedge clk_i) disable iff (reset_i)
		result_i.valid |-> result_i.alu_result == expect_q2.alu_result)
		else begin
			fail_count++;
			$error("FAIL %0t: alu result %h, expected %h", $time,
				$sampled(result_i.alu_result), $sampled(expect_q2.alu_result));
		end

	a_store: assert property (@(posedge clk_i) disable iff (reset_i)
		result_i.valid && expect_q2.mem_we |-> result_i.mem_wdata == expect_q2.mem_wdata)
		else begin
			fail_count++;
			$error("FAIL %0t: store data %h, expected %h", $time,
				$sampled(result_i.mem_wdata), $sampled(expect_q2.mem_wdata));
		end

endmodule

bind rv_exe_top rv_exe_top_chk #(
	.PC_RESET (PC_RESET)
) u_chk (
	.clk_i      (clk_i),
	.reset_i    (reset_i),
	.valid_i    (valid_i),
	.inst_i     (inst_i),
	.pc_i       (pc_i),
	.rs1_data_i (rs1_data_i),
	.rs2_data_i (rs2_data_i),
	.result_i   (result_o)
);

// ==== sim/tb_rv_exe_top.sv ====
`timescale 1ns/1ps
//********************
// testbench for rv_exe_top, values checked by the bound checker
// register values and immediates from a 16-bit galois lfsr
//********************
module tb_rv_exe_top;
	import rv_exe_pkg::*;

	localparam logic [6:0] OPC_OP     = 7'h33;
	localparam logic [6:0] OPC_OP_IMM = 7'h13;
	localparam logic [6:0] OPC_LUI    = 7'h37;
	localparam logic [6:0] OPC_AUIPC  = 7'h17;
	localparam logic [6:0] OPC_JAL    = 7'h6f;
	localparam logic [6:0] OPC_JALR   = 7'h67;
	localparam logic [6:0] OPC_BRANCH = 7'h63;
	localparam logic [6:0] OPC_LOAD   = 7'h03;
	localparam logic [6:0] OPC_STORE  = 7'h23;
	// reset, idle after reset, 114 instructions, about 5 drain cycles per test
	localparam int NEED_CYCLES = 16 + 6 + 114 + 7 * 5;
	localparam int CYCLE_LIMIT = NEED_CYCLES * 3 / 2;

	logic        clk;
	logic        reset;
	logic        valid;
	logic [31:0] inst;
	logic [31:0] pc;
	logic [31:0] rs1_data;
	logic [31:0] rs2_data;
	exe_result_t result;
	logic [15:0] lfsr_state = 16'd65205;
	int          sent = 0;
	int          got = 0;
	int          cycles = 0;
	int          tests_run = 0;
	int          tests_bad = 0;
	int unsigned fail_mark = 0;

	rv_exe_top #(
		.PC_RESET (32'h0000_1000)
	) u_rv_exe_top (
		.clk_i      (clk),
		.reset_i    (reset),
		.valid_i    (valid),
		.inst_i     (inst),
		.pc_i       (pc),
		.rs1_data_i (rs1_data),
		.rs2_data_i (rs2_data),
		.result_o   (result)
	);

	// taps x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// R-type goes through here too, funct7 and rs2 in the upper imm bits
	function automatic logic [31:0] itype(input logic [11:0] imm, input logic [2:0] f3,
		input logic [6:0] opc);
		logic [4:0] rs1;
		logic [4:0] rd;
		rs1 = 5'(rand_bits(5));
		rd  = 5'(rand_bits(5));
		return {imm, rs1, f3, rd, opc};
	endfunction

	// store and branch layout
	function automatic logic [31:0] stype(input logic [11:0] imm, input logic [2:0] f3,
		input logic [6:0] opc);
		logic [4:0] rs1;
		logic [4:0] rs2;
		rs1 = 5'(rand_bits(5));
		rs2 = 5'(rand_bits(5));
		return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
	endfunction

	function automatic logic [31:0] utype(input logic [19:0] imm, input logic [6:0] opc);
		logic [4:0] rd;
		rd = 5'(rand_bits(5));
		return {imm, rd, opc};
	endfunction

	task automatic send(input logic [31:0] instr, input bit same_ops);
		@(posedge clk);
		#2;
		valid    = 1'b1;
		inst     = instr;
		pc       = rand_bits(30) << 2;
		rs1_data = rand_bits(32);
		rs2_data = same_ops ? rs1_data : rand_bits(32);
		sent++;
	endtask

	task automatic end_test(input string name);
		int unsigned fails_now;
		@(posedge clk);
		#2;
		valid = 1'b0;
		wait (got == sent);
		// one more edge so the last result has been checked
		@(posedge clk);
		#2;
		fails_now = u_rv_exe_top.u_chk.fail_count - fail_mark;
		fail_mark = u_rv_exe_top.u_chk.fail_count;
		tests_run++;
		if (fails_now != 0) begin
			tests_bad++;
		end
		$display("test %-8s done at %0t, %0d results so far, %0d assertion failures",
			name, $time, got, fails_now);
	endtask

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	always @(negedge clk) begin
		if (!reset && result.valid) begin
			got++;
		end
	end

	initial begin
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, %0d of %0d results seen", cycles, got, sent);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		logic [11:0] imm;
		reset    = 1'b1;
		valid    = 1'b0;
		inst     = '0;
		pc       = '0;
		rs1_data = '0;
		rs2_data = '0;
		repeat (16) @(posedge clk);
		#2;
		reset = 1'b0;
		repeat (6) @(posedge clk);
		end_test("reset");

		for (int r = 0; r < 2; r++) begin
			for (int f = 0; f < 8; f++) begin
				send(itype({7'h00, 5'(rand_bits(5))}, 3'(f), OPC_OP), 1'b0);
			end
			send(itype({7'h20, 5'(rand_bits(5))}, 3'd0, OPC_OP), 1'b0);
			send(itype({7'h20, 5'(rand_bits(5))}, 3'd5, OPC_OP), 1'b0);
		end
		end_test("r-type");

		for (int r = 0; r < 2; r++) begin
			for (int f = 0; f < 8; f++) begin
				imm = (f == 1 || f == 5) ? {7'h00, 5'(rand_bits(5))} : 12'(rand_bits(12));
				send(itype(imm, 3'(f), OPC_OP_IMM), 1'b0);
			end
			send(itype({7'h20, 5'(rand_bits(5))}, 3'd5, OPC_OP_IMM), 1'b0);
		end
		end_test("i-type");

		for (int r = 0; r < 3; r++) begin
			send(utype(20'(rand_bits(20)), OPC_LUI), 1'b0);
			send(utype(20'(rand_bits(20)), OPC_AUIPC), 1'b0);
			send(utype(20'(rand_bits(20)), OPC_JAL), 1'b0);
			send(itype(12'(rand_bits(12)), 3'd0, OPC_JALR), 1'b0);
		end
		end_test("upper");

		// odd rounds use equal operands
		for (int r = 0; r < 4; r++) begin
			for (int f = 0; f < 8; f++) begin
				if (f != 2 && f != 3) begin
					send(stype(12'(rand_bits(12)), 3'(f), OPC_BRANCH), r[0]);
				end
			end
		end
		end_test("branch");

		for (int r = 0; r < 4; r++) begin
			for (int f = 0; f < 3; f++) begin
				send(stype(12'(rand_bits(12)), 3'(f), OPC_STORE), 1'b0);
			end
		end
		end_test("store");

		// loads back to back with arithmetic and stores in between
		for (int r = 0; r < 4; r++) begin
			for (int f = 0; f < 6; f++) begin
				if (f != 3) begin
					send(itype(12'(rand_bits(12)), 3'(f), OPC_LOAD), 1'b0);
				end
			end
			send(itype(12'(rand_bits(12)), 3'd0, OPC_OP_IMM), 1'b0);
			send(stype(12'(rand_bits(12)), 3'd2, OPC_STORE), 1'b0);
		end
		end_test("load");

		$display("%0d tests, %0d failed, %0d assertion failures, %0d instructions",
			tests_run, tests_bad, u_rv_exe_top.u_chk.fail_count, sent);
		if (tests_bad == 0 && u_rv_exe_top.u_chk.fail_count == 0 && got == sent) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== project.f ====
hw/rv_exe_pkg.sv
hw/rv_alu.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_exe_top.sv
sim/rv_exe_top_chk.sv
sim/tb_rv_exe_top.sv

// ==== Bender.yml ====
package:
  name: rv_exe

sources:
  - hw/rv_exe_pkg.sv
  - hw/rv_alu.sv
  - hw/rv_decode.sv
  - hw/rv_execute.sv
  - hw/rv_exe_top.sv
  - target: simulation
    files:
      - sim/rv_exe_top_chk.sv
      - sim/tb_rv_exe_top.sv
